// ==== logic/pacman_render_pkg.sv ====
package pacman_render_pkg;

	// widths
	localparam int COORD_W = 10;
	localparam int CHAN_W = 4;
	localparam int RGB_W = 3 * CHAN_W;
	localparam int TILE_W = 4;
	localparam int TILE_SHIFT = 4;
	localparam int ANIM_W = 5;

	// sprite box is centre +/- SPRITE_HALF on both axes
	localparam int SPRITE_HALF = 7;
	localparam int MOUTH_W0 = 0;
	localparam int MOUTH_W1 = 3;
	localparam int MOUTH_W2 = 6;

	localparam logic [1:0] STATE_START = 2'b00;
	localparam logic [1:0] STATE_LEVEL = 2'b01;
	localparam logic [1:0] STATE_OVER = 2'b10;
	localparam logic [1:0] STATE_WIN = 2'b11;

	localparam logic [1:0] DIR_LEFT = 2'b00;
	localparam logic [1:0] DIR_RIGHT = 2'b01;
	localparam logic [1:0] DIR_DOWN = 2'b10;
	localparam logic [1:0] DIR_UP = 2'b11;

	// any maze RAM code not listed here draws black
	localparam logic [TILE_W-1:0] TILE_EMPTY = 4'h0;
	localparam logic [TILE_W-1:0] TILE_WALL = 4'h1;
	localparam logic [TILE_W-1:0] TILE_FOOD = 4'h2;
	localparam logic [TILE_W-1:0] TILE_PELLET = 4'h7;
	localparam logic [TILE_W-1:0] TILE_LIVES = 4'hA;

	// colours as {red, green, blue}
	localparam logic [RGB_W-1:0] RGB_BLACK = 12'h000;
	localparam logic [RGB_W-1:0] RGB_WALL = 12'h22F;
	localparam logic [RGB_W-1:0] RGB_DOT = 12'hFBA;
	localparam logic [RGB_W-1:0] RGB_PAC = 12'hFF0;
	localparam logic [RGB_W-1:0] RGB_GHOST_RED = 12'hF00;
	localparam logic [RGB_W-1:0] RGB_GHOST_BLUE = 12'h0FF;
	localparam logic [RGB_W-1:0] RGB_GHOST_PINK = 12'hFBF;
	localparam logic [RGB_W-1:0] RGB_GHOST_ORANGE = 12'hFB5;
	localparam logic [RGB_W-1:0] RGB_GHOST_GREEN = 12'h0F0;
	localparam logic [RGB_W-1:0] RGB_FREEZE = 12'hEEF;
	localparam logic [RGB_W-1:0] RGB_FRIGHT = 12'h22F;
	localparam logic [RGB_W-1:0] RGB_START = 12'h008;
	localparam logic [RGB_W-1:0] RGB_OVER = 12'h800;
	localparam logic [RGB_W-1:0] RGB_WIN = 12'h080;

	// lives row reaches LIVES_BASE + LIVES_STEP * lives
	localparam int LIVES_BASE = 32;
	localparam int LIVES_STEP = 16;

endpackage

// ==== logic/anim_timer.sv ====
module anim_timer (
	input logic frame_clk,
	input logic reset,
	input logic frame_start,
	output logic [1:0] mouth_stage,
	output logic blink_on
);
	import pacman_render_pkg::*;

	logic [ANIM_W-1:0] count;

	// wraps at 32 by overflow
	always_ff @(posedge frame_clk) begin
		if (reset) begin
			count <= '0;
		end else if (frame_start) begin
			count <= count + 1'b1;
		end
	end

	// mouth cycle 0, 1, 2, 1
	always_comb begin
		case (count[ANIM_W-1 -: 2])
			2'd0: mouth_stage = 2'd0;
			2'd1: mouth_stage = 2'd1;
			2'd2: mouth_stage = 2'd2;
			default: mouth_stage = 2'd1;
		endcase
	end

	// pellet shown in first half of the cycle
	assign blink_on = ~count[ANIM_W-1];

	count_holds: assert property (@(posedge frame_clk) disable iff (reset)
		!frame_start |=> $stable(count));

endmodule

// ==== logic/pacman_sprite.sv ====
module pacman_sprite (
	input logic frame_clk,
	input logic reset,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_x,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_y,
	input logic [pacman_render_pkg::COORD_W-1:0] pac_x,
	input logic [pacman_render_pkg::COORD_W-1:0] pac_y,
	input logic [1:0] pac_dir,
	input logic [1:0] mouth_stage,
	output logic pac_opaque
);
	import pacman_render_pkg::*;

	logic signed [COORD_W:0] dx;
	logic signed [COORD_W:0] dy;
	logic signed [COORD_W:0] abs_dx;
	logic signed [COORD_W:0] abs_dy;
	int mouth_w;
	logic in_box;
	logic in_mouth;

	// offsets from the centre, one bit wider for the sign
	assign dx = $signed({1'b0, draw_x}) - $signed({1'b0, pac_x});
	assign dy = $signed({1'b0, draw_y}) - $signed({1'b0, pac_y});
	assign abs_dx = dx[COORD_W] ? -dx : dx;
	assign abs_dy = dy[COORD_W] ? -dy : dy;

	assign in_box = (abs_dx <= SPRITE_HALF) && (abs_dy <= SPRITE_HALF);

	always_comb begin
		case (mouth_stage)
			2'd0: mouth_w = MOUTH_W0;
			2'd1: mouth_w = MOUTH_W1;
			2'd2: mouth_w = MOUTH_W2;
			default: mouth_w = MOUTH_W1;
		endcase
	end

	// wedge opens toward the direction of travel
	always_comb begin
		case (pac_dir)
			DIR_RIGHT: in_mouth = (dx > 0) && (abs_dy < mouth_w);
			DIR_LEFT: in_mouth = (dx < 0) && (abs_dy < mouth_w);
			DIR_DOWN: in_mouth = (dy > 0) && (abs_dx < mouth_w);
			DIR_UP: in_mouth = (dy < 0) && (abs_dx < mouth_w);
			default: in_mouth = 1'b0;
		endcase
	end

	always_ff @(posedge frame_clk) begin
		if (reset) begin
			pac_opaque <= 1'b0;
		end else begin
			pac_opaque <= in_box && !in_mouth;
		end
	end

endmodule

// ==== logic/ghost_sprite.sv ====
module ghost_sprite (
	input logic frame_clk,
	input logic reset,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_x,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_y,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_x,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_y,
	output logic ghost_opaque
);
	import pacman_render_pkg::*;

	logic signed [COORD_W:0] dx;
	logic signed [COORD_W:0] dy;
	logic signed [COORD_W:0] abs_dx;
	logic signed [COORD_W:0] abs_dy;
	logic in_box;
	logic in_skirt;

	assign dx = $signed({1'b0, draw_x}) - $signed({1'b0, ghost_x});
	assign dy = $signed({1'b0, draw_y}) - $signed({1'b0, ghost_y});
	assign abs_dx = dx[COORD_W] ? -dx : dx;
	assign abs_dy = dy[COORD_W] ? -dy : dy;

	assign in_box = (abs_dx <= SPRITE_HALF) && (abs_dy <= SPRITE_HALF);

	// bottom row gaps at odd columns
	// lsb of dx is the parity on both sides of the centre
	assign in_skirt = (dy == SPRITE_HALF) && dx[0];

	always_ff @(posedge frame_clk) begin
		if (reset) begin
			ghost_opaque <= 1'b0;
		end else begin
			ghost_opaque <= in_box && !in_skirt;
		end
	end

endmodule

// ==== logic/tile_shader.sv ====
module tile_shader (
	input logic frame_clk,
	input logic reset,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_x,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_y,
	input logic [pacman_render_pkg::TILE_W-1:0] tile_code,
	input logic display_on,
	input logic blink_on,
	input logic [2:0] lives,
	output logic [pacman_render_pkg::RGB_W-1:0] tile_rgb
);
	import pacman_render_pkg::*;

	logic [TILE_SHIFT-1:0] px;
	logic [TILE_SHIFT-1:0] py;
	logic [COORD_W-1:0] lives_edge;
	logic dot_zone;
	logic pellet_zone;
	logic lives_zone;
	logic [RGB_W-1:0] tile_rgb_d;

	// position inside the 16x16 tile
	assign px = draw_x[TILE_SHIFT-1:0];
	assign py = draw_y[TILE_SHIFT-1:0];

	// 2x2 dot and 6x6 pellet, both centred
	assign dot_zone = (px >= 7) && (px <= 8) && (py >= 7) && (py <= 8);
	assign pellet_zone = (px >= 5) && (px <= 10) && (py >= 5) && (py <= 10);

	assign lives_edge = COORD_W'(LIVES_BASE + LIVES_STEP * int'(lives));
	assign lives_zone = (lives != 3'd0) && (draw_x <= lives_edge);

	always_comb begin
		tile_rgb_d = RGB_BLACK;
		if (display_on) begin
			case (tile_code)
				TILE_EMPTY: tile_rgb_d = RGB_BLACK;
				TILE_WALL: tile_rgb_d = RGB_WALL;
				TILE_FOOD: begin
					if (dot_zone) begin
						tile_rgb_d = RGB_DOT;
					end
				end
				TILE_PELLET: begin
					if (pellet_zone && blink_on) begin
						tile_rgb_d = RGB_DOT;
					end
				end
				TILE_LIVES: begin
					if (lives_zone) begin
						tile_rgb_d = RGB_PAC;
					end
				end
				default: tile_rgb_d = RGB_BLACK;
			endcase
		end
	end

	always_ff @(posedge frame_clk) begin
		if (reset) begin
			tile_rgb <= '0;
		end else begin
			tile_rgb <= tile_rgb_d;
		end
	end

	lives_range: assert property (@(posedge frame_clk) disable iff (reset)
		lives <= 3'd3);

endmodule

// ==== logic/pixel_compositor.sv ====
module pixel_compositor (
	input logic frame_clk,
	input logic reset,
	input logic [1:0] game_state,
	input logic freeze_on,
	input logic fright_on,
	input logic pac_opaque,
	input logic ghost_red_opaque,
	input logic ghost_blue_opaque,
	input logic ghost_pink_opaque,
	input logic ghost_orange_opaque,
	input logic ghost_green_opaque,
	input logic [pacman_render_pkg::RGB_W-1:0] tile_rgb,
	output logic [pacman_render_pkg::CHAN_W-1:0] red,
	output logic [pacman_render_pkg::CHAN_W-1:0] green,
	output logic [pacman_render_pkg::CHAN_W-1:0] blue
);
	import pacman_render_pkg::*;

	logic [1:0] game_state_q;
	logic freeze_q;
	logic fright_q;
	logic ghost_hit;
	logic [RGB_W-1:0] ghost_base;
	logic [RGB_W-1:0] ghost_rgb;
	logic [RGB_W-1:0] pix_rgb;

	// line up with the stage 1 sprite and tile registers
	always_ff @(posedge frame_clk) begin
		if (reset) begin
			game_state_q <= STATE_START;
			freeze_q <= 1'b0;
			fright_q <= 1'b0;
		end else begin
			game_state_q <= game_state;
			freeze_q <= freeze_on;
			fright_q <= fright_on;
		end
	end

	// ghost order red, blue, pink, orange, green
	always_comb begin
		ghost_hit = 1'b1;
		if (ghost_red_opaque) begin
			ghost_base = RGB_GHOST_RED;
		end else if (ghost_blue_opaque) begin
			ghost_base = RGB_GHOST_BLUE;
		end else if (ghost_pink_opaque) begin
			ghost_base = RGB_GHOST_PINK;
		end else if (ghost_orange_opaque) begin
			ghost_base = RGB_GHOST_ORANGE;
		end else if (ghost_green_opaque) begin
			ghost_base = RGB_GHOST_GREEN;
		end else begin
			ghost_hit = 1'b0;
			ghost_base = RGB_BLACK;
		end
	end

	// freeze wins over frighten
	assign ghost_rgb = freeze_q ? RGB_FREEZE : (fright_q ? RGB_FRIGHT : ghost_base);

	always_comb begin
		case (game_state_q)
			STATE_START: pix_rgb = RGB_START;
			STATE_OVER: pix_rgb = RGB_OVER;
			STATE_WIN: pix_rgb = RGB_WIN;
			default: begin
				if (pac_opaque) begin
					pix_rgb = RGB_PAC;
				end else if (ghost_hit) begin
					pix_rgb = ghost_rgb;
				end else begin
					pix_rgb = tile_rgb;
				end
			end
		endcase
	end

	always_ff @(posedge frame_clk) begin
		if (reset) begin
			{red, green, blue} <= '0;
		end else begin
			{red, green, blue} <= pix_rgb;
		end
	end

	black_after_reset: assert property (@(posedge frame_clk)
		reset |=> (red == '0) && (green == '0) && (blue == '0));

endmodule

// ==== logic/pacman_map_top.sv ====
module pacman_map_top (
	input logic frame_clk,
	input logic reset,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_x,
	input logic [pacman_render_pkg::COORD_W-1:0] draw_y,
	input logic display_on,
	input logic [pacman_render_pkg::TILE_W-1:0] tile_code,
	input logic frame_start,
	input logic [pacman_render_pkg::COORD_W-1:0] pac_x,
	input logic [pacman_render_pkg::COORD_W-1:0] pac_y,
	input logic [1:0] pac_dir,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_red_x,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_red_y,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_blue_x,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_blue_y,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_pink_x,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_pink_y,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_orange_x,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_orange_y,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_green_x,
	input logic [pacman_render_pkg::COORD_W-1:0] ghost_green_y,
	input logic [2:0] lives,
	input logic [1:0] game_state,
	input logic freeze_on,
	input logic fright_on,
	output logic [pacman_render_pkg::CHAN_W-1:0] red,
	output logic [pacman_render_pkg::CHAN_W-1:0] green,
	output logic [pacman_render_pkg::CHAN_W-1:0] blue
);
	import pacman_render_pkg::*;

	logic [1:0] mouth_stage;
	logic blink_on;
	logic pac_opaque;
	logic ghost_red_opaque;
	logic ghost_blue_opaque;
	logic ghost_pink_opaque;
	logic ghost_orange_opaque;
	logic ghost_green_opaque;
	logic [RGB_W-1:0] tile_rgb;

	anim_timer timer (
		.frame_clk   (frame_clk),
		.reset       (reset),
		.frame_start (frame_start),
		.mouth_stage (mouth_stage),
		.blink_on    (blink_on)
	);

	// stage 1
	pacman_sprite pacman (
		.frame_clk   (frame_clk),
		.reset       (reset),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.pac_x       (pac_x),
		.pac_y       (pac_y),
		.pac_dir     (pac_dir),
		.mouth_stage (mouth_stage),
		.pac_opaque  (pac_opaque)
	);

	ghost_sprite ghost_red (
		.frame_clk (frame_clk), .reset (reset), .draw_x (draw_x), .draw_y (draw_y),
		.ghost_x (ghost_red_x), .ghost_y (ghost_red_y), .ghost_opaque (ghost_red_opaque)
	);

	ghost_sprite ghost_blue (
		.frame_clk (frame_clk), .reset (reset), .draw_x (draw_x), .draw_y (draw_y),
		.ghost_x (ghost_blue_x), .ghost_y (ghost_blue_y), .ghost_opaque (ghost_blue_opaque)
	);

	ghost_sprite ghost_pink (
		.frame_clk (frame_clk), .reset (reset), .draw_x (draw_x), .draw_y (draw_y),
		.ghost_x (ghost_pink_x), .ghost_y (ghost_pink_y), .ghost_opaque (ghost_pink_opaque)
	);

	ghost_sprite ghost_orange (
		.frame_clk (frame_clk), .reset (reset), .draw_x (draw_x), .draw_y (draw_y),
		.ghost_x (ghost_orange_x), .ghost_y (ghost_orange_y),
		.ghost_opaque (ghost_orange_opaque)
	);

	ghost_sprite ghost_green (
		.frame_clk (frame_clk), .reset (reset), .draw_x (draw_x), .draw_y (draw_y),
		.ghost_x (ghost_green_x), .ghost_y (ghost_green_y),
		.ghost_opaque (ghost_green_opaque)
	);

	tile_shader shader (
		.frame_clk  (frame_clk),
		.reset      (reset),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.tile_code  (tile_code),
		.display_on (display_on),
		.blink_on   (blink_on),
		.lives      (lives),
		.tile_rgb   (tile_rgb)
	);

	// stage 2
	pixel_compositor compositor (
		.frame_clk           (frame_clk),
		.reset               (reset),
		.game_state          (game_state),
		.freeze_on           (freeze_on),
		.fright_on           (fright_on),
		.pac_opaque          (pac_opaque),
		.ghost_red_opaque    (ghost_red_opaque),
		.ghost_blue_opaque   (ghost_blue_opaque),
		.ghost_pink_opaque   (ghost_pink_opaque),
		.ghost_orange_opaque (ghost_orange_opaque),
		.ghost_green_opaque  (ghost_green_opaque),
		.tile_rgb            (tile_rgb),
		.red                 (red),
		.green               (green),
		.blue                (blue)
	);

endmodule

// ==== verification/tb_pixel_model.svh ====
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

// mouth half-opening for each quarter of the 32-frame cycle
function automatic int mouth_open(int frame);
	case (frame / 8)
		0: return MOUTH_W0;
		1: return MOUTH_W1;
		2: return MOUTH_W2;
		default: return MOUTH_W1;
	endcase
endfunction

function automatic int magnitude(int v);
	return (v < 0) ? -v : v;
endfunction

function automatic bit inside_box(int dx, int dy);
	return (magnitude(dx) <= SPRITE_HALF) && (magnitude(dy) <= SPRITE_HALF);
endfunction

function automatic bit pac_covers(int dx, int dy, logic [1:0] dir, int frame);
	int w;
	bit mouth;
	w = mouth_open(frame);
	case (dir)
		DIR_RIGHT: mouth = (dx > 0) && (magnitude(dy) < w);
		DIR_LEFT: mouth = (dx < 0) && (magnitude(dy) < w);
		DIR_DOWN: mouth = (dy > 0) && (magnitude(dx) < w);
		default: mouth = (dy < 0) && (magnitude(dx) < w);
	endcase
	return inside_box(dx, dy) && !mouth;
endfunction

// skirt gaps sit on the bottom row at odd offsets
function automatic bit ghost_covers(int dx, int dy);
	return inside_box(dx, dy) && !((dy == SPRITE_HALF) && ((dx & 1) != 0));
endfunction

function automatic logic [RGB_W-1:0] tile_colour(int x, int y, logic [TILE_W-1:0] code,
		bit shown, int frame, int lives_n);
	int px;
	int py;
	px = x % (1 << TILE_SHIFT);
	py = y % (1 << TILE_SHIFT);
	if (!shown) begin
		return RGB_BLACK;
	end
	case (code)
		TILE_WALL: return RGB_WALL;
		TILE_FOOD: return (px inside {[7:8]} && py inside {[7:8]}) ? RGB_DOT : RGB_BLACK;
		TILE_PELLET: begin
			return (px inside {[5:10]} && py inside {[5:10]} && frame < 16) ? RGB_DOT : RGB_BLACK;
		end
		TILE_LIVES: begin
			return (lives_n != 0 && x <= LIVES_BASE + LIVES_STEP * lives_n) ? RGB_PAC : RGB_BLACK;
		end
		default: return RGB_BLACK;
	endcase
endfunction

function automatic logic [RGB_W-1:0] power_colour(logic [RGB_W-1:0] own);
	if (freeze_on) begin
		return RGB_FREEZE;
	end
	return fright_on ? RGB_FRIGHT : own;
endfunction

// colour for the inputs now on the DUT pins
function automatic logic [RGB_W-1:0] expected_pixel();
	int x;
	int y;
	x = int'(draw_x);
	y = int'(draw_y);
	case (game_state)
		STATE_START: return RGB_START;
		STATE_OVER: return RGB_OVER;
		STATE_WIN: return RGB_WIN;
		default: ;
	endcase
	if (pac_covers(x - int'(pac_x), y - int'(pac_y), pac_dir, anim_count)) begin
		return RGB_PAC;
	end
	if (ghost_covers(x - int'(ghost_red_x), y - int'(ghost_red_y))) begin
		return power_colour(RGB_GHOST_RED);
	end
	if (ghost_covers(x - int'(ghost_blue_x), y - int'(ghost_blue_y))) begin
		return power_colour(RGB_GHOST_BLUE);
	end
	if (ghost_covers(x - int'(ghost_pink_x), y - int'(ghost_pink_y))) begin
		return power_colour(RGB_GHOST_PINK);
	end
	if (ghost_covers(x - int'(ghost_orange_x), y - int'(ghost_orange_y))) begin
		return power_colour(RGB_GHOST_ORANGE);
	end
	if (ghost_covers(x - int'(ghost_green_x), y - int'(ghost_green_y))) begin
		return power_colour(RGB_GHOST_GREEN);
	end
	return tile_colour(x, y, tile_code, display_on, anim_count, int'(lives));
endfunction

task automatic check_chan(string name, logic [CHAN_W-1:0] got, logic [CHAN_W-1:0] want);
	checks++;
	if (got !== want) begin
		errors++;
		$display("FAIL %s got 0x%h expected 0x%h (%s)", name, got, want, test_name);
	end
endtask

// call on a falling edge once the inputs are set
task automatic drive_pixel();
	logic [RGB_W-1:0] want;
	expected_q.push_back(expected_pixel());
	if (frame_start) begin
		anim_count = (anim_count + 1) % 32;
	end
	@(negedge frame_clk);
	frame_start = 1'b0;
	// two pixels in flight
	if (expected_q.size() == 2) begin
		want = expected_q.pop_front();
		check_chan("red", red, want[RGB_W-1 -: CHAN_W]);
		check_chan("green", green, want[2*CHAN_W-1 -: CHAN_W]);
		check_chan("blue", blue, want[CHAN_W-1:0]);
	end
endtask

`endif

// ==== verification/tb_pacman_map.sv ====
module tb_pacman_map;
	import pacman_render_pkg::*;

	logic frame_clk;
	logic reset;
	logic [COORD_W-1:0] draw_x;
	logic [COORD_W-1:0] draw_y;
	logic display_on;
	logic [TILE_W-1:0] tile_code;
	logic frame_start;
	logic [COORD_W-1:0] pac_x;
	logic [COORD_W-1:0] pac_y;
	logic [1:0] pac_dir;
	logic [COORD_W-1:0] ghost_red_x;
	logic [COORD_W-1:0] ghost_red_y;
	logic [COORD_W-1:0] ghost_blue_x;
	logic [COORD_W-1:0] ghost_blue_y;
	logic [COORD_W-1:0] ghost_pink_x;
	logic [COORD_W-1:0] ghost_pink_y;
	logic [COORD_W-1:0] ghost_orange_x;
	logic [COORD_W-1:0] ghost_orange_y;
	logic [COORD_W-1:0] ghost_green_x;
	logic [COORD_W-1:0] ghost_green_y;
	logic [2:0] lives;
	logic [1:0] game_state;
	logic freeze_on;
	logic fright_on;
	logic [CHAN_W-1:0] red;
	logic [CHAN_W-1:0] green;
	logic [CHAN_W-1:0] blue;

	// mirror of the DUT frame counter
	int anim_count = 0;
	int checks = 0;
	int errors = 0;
	int checks_at = 0;
	int errors_at = 0;
	string test_name = "";
	logic [RGB_W-1:0] expected_q[$];

	`include "tb_pixel_model.svh"

	pacman_map_top dut0 (.*);

	initial begin
		frame_clk = 1'b0;
		forever begin
			#10 frame_clk = ~frame_clk;
		end
	end

	initial begin
		#100000;
		$display("timeout, the run did not reach its end");
		$display("TB FAILED");
		$finish;
	end

	task automatic name_test(string name);
		test_name = name;
		checks_at = checks;
		errors_at = errors;
	endtask

	task automatic report_test();
		$display("%s: %0d checks, %0d errors", test_name, checks - checks_at, errors - errors_at);
	endtask

	function automatic logic [COORD_W-1:0] near_coord();
		return COORD_W'($urandom_range(63, 0));
	endfunction

	// parked off screen so only the tile shows
	task automatic park_sprites();
		pac_x = 1000;
		pac_y = 1000;
		{ghost_red_x, ghost_red_y, ghost_blue_x, ghost_blue_y} = {4{COORD_W'(1000)}};
		{ghost_pink_x, ghost_pink_y, ghost_orange_x, ghost_orange_y} = {4{COORD_W'(1000)}};
		{ghost_green_x, ghost_green_y} = {2{COORD_W'(1000)}};
	endtask

	task automatic randomize_pixel();
		draw_x = near_coord();
		draw_y = near_coord();
		tile_code = TILE_W'($urandom);
		display_on = 1'($urandom);
		pac_x = near_coord();
		pac_y = near_coord();
		pac_dir = 2'($urandom);
		ghost_red_x = near_coord();
		ghost_red_y = near_coord();
		ghost_blue_x = near_coord();
		ghost_blue_y = near_coord();
		ghost_pink_x = near_coord();
		ghost_pink_y = near_coord();
		ghost_orange_x = near_coord();
		ghost_orange_y = near_coord();
		ghost_green_x = near_coord();
		ghost_green_y = near_coord();
		lives = 3'($urandom_range(3, 0));
		freeze_on = 1'($urandom);
		fright_on = 1'($urandom);
		frame_start = ($urandom_range(3, 0) == 0);
	endtask

	task automatic reset_and_latency();
		name_test("reset and latency");
		repeat (16) @(negedge frame_clk);
		check_chan("red", red, '0);
		check_chan("green", green, '0);
		check_chan("blue", blue, '0);
		reset = 1'b0;
		for (int i = 0; i < 48; i++) begin
			randomize_pixel();
			game_state = STATE_LEVEL;
			drive_pixel();
		end
		report_test();
	endtask

	task automatic screen_states();
		logic [1:0] states[3] = '{STATE_START, STATE_OVER, STATE_WIN};
		name_test("screen states");
		for (int s = 0; s < 3; s++) begin
			for (int i = 0; i < 8; i++) begin
				randomize_pixel();
				pac_x = draw_x;
				pac_y = draw_y;
				game_state = states[s];
				drive_pixel();
			end
		end
		report_test();
	endtask

	task automatic tile_patterns();
		int edges[5];
		name_test("tiles");
		park_sprites();
		game_state = STATE_LEVEL;
		{freeze_on, fright_on, display_on} = 3'b001;
		lives = 3'd0;
		tile_code = TILE_WALL;
		for (int i = 0; i < 4; i++) begin
			draw_x = near_coord();
			draw_y = near_coord();
			drive_pixel();
		end
		// food dot along a diagonal and across its middle row
		tile_code = TILE_FOOD;
		for (int p = 0; p < 16; p++) begin
			draw_x = COORD_W'(160 + p);
			draw_y = COORD_W'(48 + p);
			drive_pixel();
			draw_y = COORD_W'(48 + 7);
			drive_pixel();
		end
		tile_code = TILE_LIVES;
		draw_y = 8;
		for (int l = 0; l < 4; l++) begin
			lives = 3'(l);
			edges = '{0, 31, 32 + 16 * l, 33 + 16 * l, 100};
			foreach (edges[k]) begin
				draw_x = COORD_W'(edges[k]);
				drive_pixel();
			end
		end
		for (int c = 0; c < 16; c++) begin
			tile_code = TILE_W'(c);
			draw_x = 88;
			draw_y = 72;
			drive_pixel();
		end
		display_on = 1'b0;
		for (int c = 0; c < 16; c++) begin
			tile_code = TILE_W'(c);
			drive_pixel();
		end
		display_on = 1'b1;
		report_test();
	endtask

	task automatic pacman_animation();
		int along[2] = '{3, -3};
		int across[3] = '{0, 2, 5};
		name_test("pacman animation");
		park_sprites();
		game_state = STATE_LEVEL;
		{freeze_on, fright_on, display_on} = 3'b001;
		pac_x = 320;
		pac_y = 240;
		for (int dir = 0; dir < 4; dir++) begin
			pac_dir = 2'(dir);
			for (int f = 0; f < 32; f++) begin
				tile_code = TILE_EMPTY;
				foreach (along[a]) begin
					foreach (across[b]) begin
						if (dir < 2) begin
							draw_x = COORD_W'(320 + along[a]);
							draw_y = COORD_W'(240 + across[b]);
						end else begin
							draw_x = COORD_W'(320 + across[b]);
							draw_y = COORD_W'(240 + along[a]);
						end
						drive_pixel();
					end
				end
				// pellet centre, then next frame
				tile_code = TILE_PELLET;
				draw_x = 16 * 30 + 8;
				draw_y = 16 * 10 + 8;
				frame_start = 1'b1;
				drive_pixel();
			end
		end
		report_test();
	endtask

	task automatic ghost_layers();
		name_test("ghosts");
		game_state = STATE_LEVEL;
		display_on = 1'b1;
		// black background keeps the fright colour apart from a wall
		tile_code = TILE_EMPTY;
		{pac_x, pac_y, pac_dir} = {COORD_W'(200), COORD_W'(200), DIR_RIGHT};
		{ghost_red_x, ghost_red_y} = {COORD_W'(203), COORD_W'(200)};
		{ghost_blue_x, ghost_blue_y} = {COORD_W'(206), COORD_W'(200)};
		{ghost_pink_x, ghost_pink_y} = {COORD_W'(209), COORD_W'(200)};
		{ghost_orange_x, ghost_orange_y} = {COORD_W'(212), COORD_W'(200)};
		{ghost_green_x, ghost_green_y} = {COORD_W'(215), COORD_W'(200)};
		for (int mode = 0; mode < 4; mode++) begin
			freeze_on = mode[1];
			fright_on = mode[0];
			// centre row, then the skirt row
			for (int row = 0; row < 2; row++) begin
				draw_y = (row == 0) ? COORD_W'(200) : COORD_W'(207);
				for (int x = 190; x < 225; x++) begin
					draw_x = COORD_W'(x);
					drive_pixel();
				end
			end
		end
		report_test();
	endtask

	initial begin
		void'($urandom(75713));
		reset = 1'b1;
		frame_start = 1'b0;
		{draw_x, draw_y, display_on, tile_code, pac_dir} = '0;
		park_sprites();
		{lives, game_state, freeze_on, fright_on} = '0;
		reset_and_latency();
		screen_states();
		tile_patterns();
		pacman_animation();
		ghost_layers();
		drive_pixel();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verification
logic/pacman_render_pkg.sv
logic/anim_timer.sv
logic/pacman_sprite.sv
logic/ghost_sprite.sv
logic/tile_shader.sv
logic/pixel_compositor.sv
logic/pacman_map_top.sv
verification/tb_pacman_map.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_pacman_map -o tb_pacman_map \
	&& ./obj_dir/tb_pacman_map | tee /dev/stderr | grep "TB PASSED" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
